// ==== source/bitcount_pkg.sv ====
// ====================
// Shared widths, operation codes and stage records of the bit-counting unit
// ====================
`default_nettype none

package bitcount_pkg;

  // Operand width of the integer pipeline
  localparam int unsigned XLEN = 32;

  // A count must hold every value from 0 up to XLEN inclusive
  localparam int unsigned CNT_W = $clog2(XLEN + 1);

  // Width of the operation code carried with each request
  localparam int unsigned OP_W = 2;

  // All four codes are legal, so decode needs no illegal-operation path
  typedef enum logic [OP_W-1:0] {
    OP_CLZ  = 2'd0,
    OP_CTZ  = 2'd1,
    OP_CPOP = 2'd2,
    OP_NORM = 2'd3
  } bitcount_op_e;

  // Request as it arrives at the top level together with valid_i
  typedef struct packed {
    bitcount_op_e      op;
    logic [XLEN-1:0]   operand;
  } bitcount_req_t;

  // Decoded control word handed from decode to execute
  // At most one of the three flags is set and none of them means CLZ
  typedef struct packed {
    logic              sel_trailing;
    logic              sel_popcount;
    logic              sel_shift;
    logic [XLEN-1:0]   operand;
  } bitcount_ctrl_t;

  // Everything the result stage needs to pick the final word
  typedef struct packed {
    logic              sel_trailing;
    logic              sel_popcount;
    logic              sel_shift;
    // Leading or trailing count, already forced to XLEN for a zero operand
    logic [CNT_W-1:0]  zero_cnt;
    logic [CNT_W-1:0]  pop_cnt;
    logic [XLEN-1:0]   norm_word;
    logic              operand_zero;
  } bitcount_exec_t;

  // Response word and the flag that marks a zero operand
  typedef struct packed {
    logic [XLEN-1:0]   result;
    logic              zero;
  } bitcount_rsp_t;

endpackage

`default_nettype wire

// ==== source/lzc.sv ====
// ====================
// Purely combinational, WIDTH must be at least 2
// An all-zero input raises empty_o and returns WIDTH-1 on cnt_o
// ====================
`timescale 1ns/1ps
`default_nettype none

module lzc #(
  // Number of input bits to scan
  parameter int unsigned WIDTH = 2,
  // Set for a leading zero count, clear for a trailing zero count
  parameter bit          MODE  = 1'b0
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  // Input reordered so that the scan always starts at bit 0
  logic [WIDTH-1:0] in_ord;

  // Heap-ordered tree, node 0 is the root and level l starts at 2**l - 1
  // Each node tells whether any bit below it is set
  logic [2**$clog2(WIDTH)-2:0] node_hit;

  // Each node keeps the position of the first set bit below it
  logic [2**$clog2(WIDTH)-2:0][$clog2(WIDTH)-1:0] node_idx;

  // In leading mode the MSB becomes position 0 of the scan
  for (genvar i = 0; i < WIDTH; i++) begin : g_order
    assign in_ord[i] = MODE ? in_i[WIDTH-1-i] : in_i[i];
  end

  for (genvar lvl = 0; lvl < $clog2(WIDTH); lvl++) begin : g_level
    if (lvl == $clog2(WIDTH) - 1) begin : g_leaf
      // The bottom level looks at input bits in pairs
      for (genvar k = 0; k < 2**lvl; k++) begin : g_node
        if (2*k + 1 < WIDTH) begin : g_pair
          assign node_hit[2**lvl-1+k] = in_ord[2*k] | in_ord[2*k+1];
          // The lower position wins when both bits are set
          assign node_idx[2**lvl-1+k] = in_ord[2*k] ?
                                        ($clog2(WIDTH))'(2*k) :
                                        ($clog2(WIDTH))'(2*k+1);
        end else if (2*k < WIDTH) begin : g_single
          // Odd widths leave one bit without a partner
          assign node_hit[2**lvl-1+k] = in_ord[2*k];
          assign node_idx[2**lvl-1+k] = ($clog2(WIDTH))'(2*k);
        end else begin : g_pad
          // Padding leaves never hit
          // Their index is WIDTH-1 so an empty input still reports WIDTH-1
          assign node_hit[2**lvl-1+k] = 1'b0;
          assign node_idx[2**lvl-1+k] = ($clog2(WIDTH))'(WIDTH-1);
        end
      end
    end else begin : g_inner
      // Upper levels merge two children and prefer the left one
      for (genvar k = 0; k < 2**lvl; k++) begin : g_node
        assign node_hit[2**lvl-1+k] = node_hit[2**(lvl+1)-1+2*k] |
                                      node_hit[2**(lvl+1)+2*k];
        assign node_idx[2**lvl-1+k] = node_hit[2**(lvl+1)-1+2*k] ?
                                      node_idx[2**(lvl+1)-1+2*k] :
                                      node_idx[2**(lvl+1)+2*k];
      end
    end
  end

  // With nothing set every node falls through to its right child,
  // which ends at position WIDTH-1
  assign cnt_o   = node_idx[0];
  assign empty_o = ~node_hit[0];

endmodule

`default_nettype wire

// ==== source/bitcount_decode.sv ====
// ====================
// First stage, one cycle, accepts a request on every edge with valid_i
// ====================
`timescale 1ns/1ps
`default_nettype none

module bitcount_decode (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         valid_i,
  input  bitcount_pkg::bitcount_req_t  req_i,
  output logic                         valid_o,
  output bitcount_pkg::bitcount_ctrl_t ctrl_o
);

  // Control word built from the incoming request
  bitcount_pkg::bitcount_ctrl_t ctrl_d;

  // Registered control word for execute
  bitcount_pkg::bitcount_ctrl_t ctrl_q;

  // Valid bit travelling with ctrl_q
  logic valid_q;

  // Translate the operation code into select flags
  // Later stages never see the code itself
  always_comb begin
    ctrl_d              = '0;
    ctrl_d.operand      = req_i.operand;
    unique case (req_i.op)
      bitcount_pkg::OP_CLZ: begin
        // Leading count is the default path and needs no flag
        ctrl_d.sel_trailing = 1'b0;
      end
      bitcount_pkg::OP_CTZ: begin
        ctrl_d.sel_trailing = 1'b1;
      end
      bitcount_pkg::OP_CPOP: begin
        ctrl_d.sel_popcount = 1'b1;
      end
      bitcount_pkg::OP_NORM: begin
        ctrl_d.sel_shift    = 1'b1;
      end
      default: begin
        ctrl_d.sel_trailing = 1'b0;
      end
    endcase
  end

  // Valid bit is control state and clears on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Payload only loads with a new request
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      ctrl_q <= ctrl_d;
    end
  end

  assign valid_o = valid_q;
  assign ctrl_o  = ctrl_q;

endmodule

`default_nettype wire

// ==== source/bitcount_execute.sv ====
// ====================
// Second stage, one cycle, zero counts saturate at XLEN for a zero operand
// ====================
`timescale 1ns/1ps
`default_nettype none

module bitcount_execute (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         valid_i,
  input  bitcount_pkg::bitcount_ctrl_t ctrl_i,
  output logic                         valid_o,
  output bitcount_pkg::bitcount_exec_t exec_o
);

  // Raw counter outputs, one bit narrower than a full count
  logic [$clog2(bitcount_pkg::XLEN)-1:0] lead_cnt;
  logic [$clog2(bitcount_pkg::XLEN)-1:0] trail_cnt;
  logic                                  lead_empty;
  logic                                  trail_empty;

  // Adder tree in heap order with the operand bits as leaves
  logic [2*bitcount_pkg::XLEN-2:0][bitcount_pkg::CNT_W-1:0] pop_node;

  // Next value of the execute register
  bitcount_pkg::bitcount_exec_t exec_d;
  bitcount_pkg::bitcount_exec_t exec_q;
  logic                         valid_q;

  // Counter scanning from the MSB
  lzc #(
    .WIDTH (bitcount_pkg::XLEN),
    .MODE  (1'b1)
  ) u_lzc_lead (
    .in_i    (ctrl_i.operand),
    .cnt_o   (lead_cnt),
    .empty_o (lead_empty)
  );

  // Counter scanning from the LSB
  lzc #(
    .WIDTH (bitcount_pkg::XLEN),
    .MODE  (1'b0)
  ) u_lzc_trail (
    .in_i    (ctrl_i.operand),
    .cnt_o   (trail_cnt),
    .empty_o (trail_empty)
  );

  // Each leaf is one operand bit widened to a full count
  for (genvar b = 0; b < bitcount_pkg::XLEN; b++) begin : g_pop_leaf
    assign pop_node[bitcount_pkg::XLEN-1+b] = (bitcount_pkg::CNT_W)'(ctrl_i.operand[b]);
  end

  // Internal nodes add their two children, node 0 holds the total
  for (genvar n = 0; n < bitcount_pkg::XLEN - 1; n++) begin : g_pop_sum
    assign pop_node[n] = pop_node[2*n+1] + pop_node[2*n+2];
  end

  always_comb begin
    exec_d.sel_trailing = ctrl_i.sel_trailing;
    exec_d.sel_popcount = ctrl_i.sel_popcount;
    exec_d.sel_shift    = ctrl_i.sel_shift;
    // An empty counter reports XLEN-1, so the full count replaces it
    if (ctrl_i.sel_trailing) begin
      exec_d.zero_cnt = trail_empty ? (bitcount_pkg::CNT_W)'(bitcount_pkg::XLEN) :
                                      (bitcount_pkg::CNT_W)'(trail_cnt);
    end else begin
      exec_d.zero_cnt = lead_empty ? (bitcount_pkg::CNT_W)'(bitcount_pkg::XLEN) :
                                     (bitcount_pkg::CNT_W)'(lead_cnt);
    end
    exec_d.pop_cnt      = pop_node[0];
    // A zero operand shifted by any amount stays zero
    exec_d.norm_word    = ctrl_i.operand << lead_cnt;
    exec_d.operand_zero = lead_empty;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      exec_q <= exec_d;
    end
  end

  assign valid_o = valid_q;
  assign exec_o  = exec_q;

endmodule

`default_nettype wire

// ==== source/bitcount_result.sv ====
// ====================
// Last stage, one cycle, a response not taken when valid_o is high is lost
// ====================
`timescale 1ns/1ps
`default_nettype none

module bitcount_result (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         valid_i,
  input  bitcount_pkg::bitcount_exec_t exec_i,
  output logic                         valid_o,
  output bitcount_pkg::bitcount_rsp_t  rsp_o
);

  // Response assembled from the execute record
  bitcount_pkg::bitcount_rsp_t rsp_d;

  // Output registers
  bitcount_pkg::bitcount_rsp_t rsp_q;
  logic                        valid_q;

  // Normalize has priority, then population count, then the zero count
  // Decode never sets more than one flag, so the order only fixes the mux shape
  always_comb begin
    rsp_d.zero = exec_i.operand_zero;
    if (exec_i.sel_shift) begin
      rsp_d.result = exec_i.norm_word;
    end else if (exec_i.sel_popcount) begin
      rsp_d.result = (bitcount_pkg::XLEN)'(exec_i.pop_cnt);
    end else begin
      // Leading or trailing was already chosen in execute
      rsp_d.result = (bitcount_pkg::XLEN)'(exec_i.zero_cnt);
    end
  end

  // The output strobe clears on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // The response word holds its value between strobes
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_q <= rsp_d;
    end
  end

  assign valid_o = valid_q;
  assign rsp_o   = rsp_q;

endmodule

`default_nettype wire

// ==== source/bitcount_unit.sv ====
// ====================
// Response follows its request by three register stages, no back-pressure
// ====================
`timescale 1ns/1ps
`default_nettype none

module bitcount_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        valid_i,
  input  bitcount_pkg::bitcount_req_t req_i,
  output logic                        valid_o,
  output bitcount_pkg::bitcount_rsp_t rsp_o
);

  // Decode to execute
  logic                         dec_valid;
  bitcount_pkg::bitcount_ctrl_t dec_ctrl;

  // Execute to result
  logic                         exe_valid;
  bitcount_pkg::bitcount_exec_t exe_data;

  // Operation code becomes select flags here
  bitcount_decode u_decode (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .valid_o (dec_valid),
    .ctrl_o  (dec_ctrl)
  );

  // Counters, adder tree and shifter
  bitcount_execute u_execute (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (dec_valid),
    .ctrl_i  (dec_ctrl),
    .valid_o (exe_valid),
    .exec_o  (exe_data)
  );

  // Final word selection and output strobe
  bitcount_result u_result (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (exe_valid),
    .exec_i  (exe_data),
    .valid_o (valid_o),
    .rsp_o   (rsp_o)
  );

endmodule

`default_nettype wire

// ==== test/bitcount_unit_properties.sv ====
// ====================
// Bound into bitcount_unit, reports only through assertion failures
// ====================
`timescale 1ns/1ps
`default_nettype none

module bitcount_unit_properties (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        valid_i,
  input bitcount_pkg::bitcount_req_t req_i,
  input logic                        valid_o,
  input bitcount_pkg::bitcount_rsp_t rsp_o
);

  // Reset on the last three edges, the pipeline is flushed once this is zero
  logic [2:0]                 reset_hist;
  // Operation code delayed to line up with valid_o
  bitcount_pkg::bitcount_op_e op_d1;
  bitcount_pkg::bitcount_op_e op_d2;
  bitcount_pkg::bitcount_op_e op_d3;

  always_ff @(posedge clk_i) begin
    reset_hist <= {reset_hist[1:0], reset_i};
    op_d1      <= req_i.op;
    op_d2      <= op_d1;
    op_d3      <= op_d2;
  end

  a_valid_delay: assert property (@(posedge clk_i) disable iff (reset_i)
    (reset_hist == 3'b000) |-> (valid_o == $past(valid_i, 3)))
    else $error("valid_o does not follow valid_i by three cycles");

  a_valid_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> !valid_o)
    else $error("valid_o is high right after reset");

  // Zero operand gives the full count for CLZ and CTZ and zero otherwise
  a_zero_result: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && rsp_o.zero) |->
    ((op_d3 == bitcount_pkg::OP_CLZ || op_d3 == bitcount_pkg::OP_CTZ) ?
     (rsp_o.result == 32'(bitcount_pkg::XLEN)) : (rsp_o.result == 32'd0)))
    else $error("zero flag set with an unexpected result word");

endmodule

bind bitcount_unit bitcount_unit_properties u_properties (.*);

`default_nettype wire

// ==== test/bitcount_unit_tb.sv ====
// ====================
// Requests go out back to back and each response must come 3 edges later
// Run time is capped by a watchdog sized from the number of requests
// ====================
`timescale 1ns/1ps
`default_nettype none

module bitcount_unit_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_DIRECTED = 16;
  localparam int NUM_RANDOM   = 64;
  localparam int TIMEOUT_NS   = (NUM_DIRECTED + NUM_RANDOM + 20) * CLK_PERIOD;

  // One row of the directed table
  typedef struct packed {
    bitcount_pkg::bitcount_op_e op;
    logic [31:0]                operand;
    logic [31:0]                result;
    logic                       zero;
  } vector_t;

  logic                        clk_i;
  logic                        reset_i;
  logic                        valid_i;
  bitcount_pkg::bitcount_req_t req_i;
  logic                        valid_o;
  bitcount_pkg::bitcount_rsp_t rsp_o;

  // Rising edges seen so far, bumped just before the clock rises
  int edge_count = 0;

  // Scoreboard entries waiting for their response
  string       name_q[$];
  logic [31:0] result_q[$];
  logic        zero_q[$];
  int          due_q[$];

  int          value_errors    = 0;
  int          protocol_errors = 0;
  logic [31:0] lfsr_state      = 32'd31;

  // Variables of the response monitor
  string       got_name;
  logic [31:0] got_result;
  logic        got_zero;
  int          got_due;

  vector_t directed [NUM_DIRECTED] = '{
    '{bitcount_pkg::OP_CLZ,  32'h0000_0000, 32'd32,        1'b1},
    '{bitcount_pkg::OP_CLZ,  32'h0000_0001, 32'd31,        1'b0},
    '{bitcount_pkg::OP_CLZ,  32'h8000_0000, 32'd0,         1'b0},
    '{bitcount_pkg::OP_CLZ,  32'h0001_2345, 32'd15,        1'b0},
    '{bitcount_pkg::OP_CLZ,  32'h0000_00FF, 32'd24,        1'b0},
    '{bitcount_pkg::OP_CTZ,  32'h0000_0000, 32'd32,        1'b1},
    '{bitcount_pkg::OP_CTZ,  32'h1234_5679, 32'd0,         1'b0},
    '{bitcount_pkg::OP_CTZ,  32'hFFFF_FFFF, 32'd0,         1'b0},
    '{bitcount_pkg::OP_CTZ,  32'h8000_0000, 32'd31,        1'b0},
    '{bitcount_pkg::OP_CTZ,  32'h0001_2300, 32'd8,         1'b0},
    '{bitcount_pkg::OP_CPOP, 32'h0000_0000, 32'd0,         1'b1},
    '{bitcount_pkg::OP_CPOP, 32'hFFFF_FFFF, 32'd32,        1'b0},
    '{bitcount_pkg::OP_CPOP, 32'hF0F0_000F, 32'd12,        1'b0},
    '{bitcount_pkg::OP_NORM, 32'h0000_0000, 32'h0000_0000, 1'b1},
    '{bitcount_pkg::OP_NORM, 32'h0000_0001, 32'h8000_0000, 1'b0},
    '{bitcount_pkg::OP_NORM, 32'h0001_2345, 32'h91A2_8000, 1'b0}
  };

  string directed_name [NUM_DIRECTED] = '{
    "clz_zero", "clz_one", "clz_msb", "clz_mid", "clz_low_byte",
    "ctz_zero", "ctz_odd", "ctz_all_ones", "ctz_msb", "ctz_mid",
    "cpop_zero", "cpop_all_ones", "cpop_mixed",
    "norm_zero", "norm_one", "norm_mid"
  };

  bitcount_unit dut (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .valid_o (valid_o),
    .rsp_o   (rsp_o)
  );

  // Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Zeros above the highest set bit, 32 when nothing is set
  function automatic int ref_clz(input logic [31:0] x);
    int n;
    n = 0;
    for (int b = 31; b >= 0; b--) begin
      if (x[b]) break;
      n++;
    end
    return n;
  endfunction

  // Zeros below the lowest set bit, 32 when nothing is set
  function automatic int ref_ctz(input logic [31:0] x);
    int n;
    n = 0;
    for (int b = 0; b < 32; b++) begin
      if (x[b]) break;
      n++;
    end
    return n;
  endfunction

  function automatic int ref_cpop(input logic [31:0] x);
    int n;
    n = 0;
    for (int b = 0; b < 32; b++) begin
      if (x[b]) n++;
    end
    return n;
  endfunction

  // Bit 31 ends up set for any nonzero operand
  function automatic logic [31:0] ref_norm(input logic [31:0] x);
    if (x == 32'd0) return 32'd0;
    return x << ref_clz(x);
  endfunction

  function automatic logic [31:0] model_result(input bitcount_pkg::bitcount_op_e op,
                                               input logic [31:0] x);
    case (op)
      bitcount_pkg::OP_CLZ:  return ref_clz(x);
      bitcount_pkg::OP_CTZ:  return ref_ctz(x);
      bitcount_pkg::OP_CPOP: return ref_cpop(x);
      default:               return ref_norm(x);
    endcase
  endfunction

  // One LFSR step per operand bit, 32 steps per operand
  task automatic next_operand(output logic [31:0] value);
    value = 32'd0;
    for (int b = 0; b < 32; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Drive one request on the next edge and log what should come back
  task automatic send_request(input string name, input bitcount_pkg::bitcount_op_e op,
                              input logic [31:0] operand, input logic [31:0] exp_result,
                              input logic exp_zero);
    @(posedge clk_i);
    valid_i       <= 1'b1;
    req_i.op      <= op;
    req_i.operand <= operand;
    name_q.push_back(name);
    result_q.push_back(exp_result);
    zero_q.push_back(exp_zero);
    // Decode loads it on the following edge and valid_o rises two edges after that
    due_q.push_back(edge_count + 3);
  endtask

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      edge_count = edge_count + 1;
      clk_i      = 1'b1;
      #(CLK_PERIOD / 2);
      clk_i      = 1'b0;
    end
  end

  // Outputs are read on the falling edge, half a period after they change
  always @(negedge clk_i) begin
    if (valid_o) begin
      if (name_q.size() == 0) begin
        $display("Error: a response came out with no request outstanding");
        protocol_errors++;
      end else begin
        got_name   = name_q.pop_front();
        got_result = result_q.pop_front();
        got_zero   = zero_q.pop_front();
        got_due    = due_q.pop_front();
        assert (rsp_o.result == got_result) else begin
          $display("Fail %s: result expected %h actual %h", got_name, got_result,
                   rsp_o.result);
          value_errors++;
        end
        assert (rsp_o.zero == got_zero) else begin
          $display("Fail %s: zero flag expected %b actual %b", got_name, got_zero,
                   rsp_o.zero);
          value_errors++;
        end
        assert (edge_count == got_due) else begin
          $display("Error: response to %s came on edge %0d but was due on edge %0d",
                   got_name, edge_count, got_due);
          protocol_errors++;
        end
      end
    end
  end

  initial begin
    logic [31:0]                operand;
    bitcount_pkg::bitcount_op_e op;
    reset_i = 1'b1;
    // A request held through reset must never reach valid_o
    valid_i = 1'b1;
    req_i   = '0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    valid_i <= 1'b0;
    // A short idle gap, where valid_o must stay low
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < NUM_DIRECTED; i++) begin
      send_request(directed_name[i], directed[i].op, directed[i].operand,
                   directed[i].result, directed[i].zero);
    end
    // The random phase follows without a gap and walks through all four codes
    for (int i = 0; i < NUM_RANDOM; i++) begin
      next_operand(operand);
      op = bitcount_pkg::bitcount_op_e'(i[1:0]);
      send_request($sformatf("random_%0d", i), op, operand, model_result(op, operand),
                   operand == 32'd0);
    end
    @(posedge clk_i);
    valid_i <= 1'b0;
    for (int k = 0; k < 8 && name_q.size() != 0; k++) begin
      @(posedge clk_i);
    end
    if (name_q.size() != 0) begin
      $display("Error: %0d responses never came out", name_q.size());
      protocol_errors++;
    end
    $display("Summary: %0d value errors, %0d protocol errors", value_errors,
             protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Error: watchdog expired with %0d responses outstanding", name_q.size());
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bitcount_unit.f ====
source/bitcount_pkg.sv
source/lzc.sv
source/bitcount_decode.sv
source/bitcount_execute.sv
source/bitcount_result.sv
source/bitcount_unit.sv
test/bitcount_unit_properties.sv
test/bitcount_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bit-counting unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module bitcount_unit_tb \
  -f bitcount_unit.f \
  -o bitcount_sim

status=0
./obj_dir/bitcount_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed (exit status $status)"
exit 1
